// File: source/rafiFront_defs.svh
// ********************
// buffer depth must stay a power of two, pointers wrap without a compare
// ********************
`ifndef RAFI_FRONT_DEFS_SVH
`define RAFI_FRONT_DEFS_SVH

// halfword slots in the instruction buffer
`define BUF_DEPTH 8

// pointer width, log2 of the depth
`define BUF_PTR_W 3

// count width, one bit more than the pointer so a full buffer is visible
`define BUF_CNT_W 4

// exception codes as defined by the privileged spec
`define TRAP_ILLEGAL_INSN 4'd2
`define TRAP_INSN_PAGE_FAULT 4'd12

// width of a CSR address in the SYSTEM encoding
`define CSR_ADDR_W 12

`endif

// File: source/rafiFrontPkg.sv
// ********************
// types shared by the decode front end
// ********************
package rafiFrontPkg;
    `include "rafiFront_defs.svh"

    // RV32 base format fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvFields_t;

    // same word seen as two buffer halfwords
    typedef struct packed {
        logic [15:0] high;
        logic [15:0] low;
    } halfPair_t;

    typedef union packed {
        rvFields_t fields;
        halfPair_t halves;
    } insnWord_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [15:0] insn;
        logic fault;
        logic interruptValid;
        logic [3:0] interruptCode;
    } bufEntry_t;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_ALU_REG,
        OP_ALU_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_SYSTEM
    } opClass_e;

    typedef struct packed {
        opClass_e opClass;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [31:0] imm;
        logic isUnknown;
    } op_t;

    typedef struct packed {
        logic valid;
        logic isInterrupt;
        logic [3:0] code;
        logic [31:0] value;
    } trapInfo_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        insnWord_u insn;
        op_t op;
        logic isCompressed;
        logic [`CSR_ADDR_W-1:0] csrAddr;
        trapInfo_t trapInfo;
    } decodeOut_t;
endpackage

// File: source/insnBuffer.sv
// ********************
// writes are dropped while full or during flush, pops are never checked
// against the count, the decode stage guarantees they are legal
// ********************
`timescale 1ns/100ps
`include "rafiFront_defs.svh"

module insnBuffer
    import rafiFrontPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic wrEn,
    input  bufEntry_t wrEntry,
    output logic full,
    output bufEntry_t readLow,
    output bufEntry_t readHigh,
    output logic [`BUF_CNT_W-1:0] readableCount,
    input  logic popLow,
    input  logic popHigh
);
    bufEntry_t entries [`BUF_DEPTH];
    logic [`BUF_PTR_W-1:0] rdPtr;
    logic [`BUF_PTR_W-1:0] rdPtrNext;
    logic [`BUF_PTR_W-1:0] wrPtr;
    logic [`BUF_CNT_W-1:0] count;
    logic push;
    logic [1:0] popCount;

    assign full = count == `BUF_CNT_W'(`BUF_DEPTH);
    assign readableCount = count;

    // flush beats a write in the same cycle
    assign push = wrEn && !full && !flush;

    // popHigh only counts together with popLow
    assign popCount = popLow ? (popHigh ? 2'd2 : 2'd1) : 2'd0;

    assign rdPtrNext = rdPtr + 1'b1;
    assign readLow = entries[rdPtr];
    assign readHigh = entries[rdPtrNext];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            rdPtr <= rdPtr + `BUF_PTR_W'(popCount);
            count <= count + `BUF_CNT_W'(push) - `BUF_CNT_W'(popCount);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= wrEntry;
        end
    end
endmodule

// File: source/opDecoder.sv
// ********************
// purely combinational, op classes only, no funct3 detail is passed on
// ********************
`timescale 1ns/100ps

module opDecoder
    import rafiFrontPkg::*;
(
    input  insnWord_u insn,
    input  logic isCompressed,
    output op_t op
);
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    rvFields_t f;
    logic [15:0] c;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    logic [31:0] immCi;
    logic [31:0] immCls;
    logic [31:0] immCj;
    logic [31:0] immCb;
    logic legal;

    // compressed 3-bit register fields name x8..x15
    function automatic logic [4:0] cReg(input logic [2:0] idx);
        return {2'b01, idx};
    endfunction

    // immediates of both formats
    always_comb begin
        f = insn.fields;
        c = insn.halves.low;
        immI = {{20{f.funct7[6]}}, f.funct7, f.rs2};
        immS = {{20{f.funct7[6]}}, f.funct7, f.rd};
        immB = {{19{f.funct7[6]}}, f.funct7[6], f.rd[0], f.funct7[5:0], f.rd[4:1], 1'b0};
        immJ = {{11{f.funct7[6]}}, f.funct7[6], f.rs1, f.funct3, f.rs2[0], f.funct7[5:0],
                f.rs2[4:1], 1'b0};
        immU = {f.funct7, f.rs2, f.rs1, f.funct3, 12'h000};
        immCi = {{26{c[12]}}, c[12], c[6:2]};
        immCls = {25'h0, c[5], c[12:10], c[6], 2'b00};
        immCj = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        immCb = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    end

    always_comb begin
        op = '0;
        legal = 1'b0;
        if (!isCompressed) begin
            op.rd = f.rd;
            op.rs1 = f.rs1;
            op.rs2 = f.rs2;
            case (f.opcode)
                OPC_OP: begin
                    op.opClass = OP_ALU_REG;
                    legal = (f.funct7 == 7'h00) ||
                            (f.funct7 == 7'h20 && f.funct3 inside {3'b000, 3'b101});
                end
                OPC_OP_IMM: begin
                    op.opClass = OP_ALU_IMM;
                    op.rs2 = '0;
                    op.imm = immI;
                    // shift forms reuse funct7 as a fixed field
                    if (f.funct3 == 3'b001) begin
                        legal = f.funct7 == 7'h00;
                    end
                    else if (f.funct3 == 3'b101) begin
                        legal = f.funct7 inside {7'h00, 7'h20};
                    end
                    else begin
                        legal = 1'b1;
                    end
                end
                OPC_LOAD: begin
                    op.opClass = OP_LOAD;
                    op.rs2 = '0;
                    op.imm = immI;
                    legal = f.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                end
                OPC_STORE: begin
                    op.opClass = OP_STORE;
                    op.rd = '0;
                    op.imm = immS;
                    legal = f.funct3 inside {3'b000, 3'b001, 3'b010};
                end
                OPC_BRANCH: begin
                    op.opClass = OP_BRANCH;
                    op.rd = '0;
                    op.imm = immB;
                    legal = !(f.funct3 inside {3'b010, 3'b011});
                end
                OPC_JAL: begin
                    op.opClass = OP_JAL;
                    op.rs1 = '0;
                    op.rs2 = '0;
                    op.imm = immJ;
                    legal = 1'b1;
                end
                OPC_JALR: begin
                    op.opClass = OP_JALR;
                    op.rs2 = '0;
                    op.imm = immI;
                    legal = f.funct3 == 3'b000;
                end
                OPC_LUI, OPC_AUIPC: begin
                    op.opClass = (f.opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                    op.rs1 = '0;
                    op.rs2 = '0;
                    op.imm = immU;
                    legal = 1'b1;
                end
                OPC_SYSTEM: begin
                    op.opClass = OP_SYSTEM;
                    op.rs2 = '0;
                    op.imm = immI;
                    legal = f.funct3 != 3'b100;
                end
                default: begin
                    legal = 1'b0;
                end
            endcase
        end
        else begin
            // funct3 and quadrant pick the form
            case ({c[15:13], c[1:0]})
                5'b010_00, 5'b110_00: begin
                    op.opClass = c[15] ? OP_STORE : OP_LOAD;
                    op.rd = c[15] ? 5'd0 : cReg(c[4:2]);
                    op.rs1 = cReg(c[9:7]);
                    op.rs2 = c[15] ? cReg(c[4:2]) : 5'd0;
                    op.imm = immCls;
                    legal = 1'b1;
                end
                5'b000_01, 5'b010_01: begin
                    // c.addi adds to rd, c.li adds to x0
                    op.opClass = OP_ALU_IMM;
                    op.rd = c[11:7];
                    op.rs1 = c[14] ? 5'd0 : c[11:7];
                    op.imm = immCi;
                    legal = 1'b1;
                end
                5'b101_01: begin
                    op.opClass = OP_JAL;
                    op.imm = immCj;
                    legal = 1'b1;
                end
                5'b110_01: begin
                    op.opClass = OP_BRANCH;
                    op.rs1 = cReg(c[9:7]);
                    op.imm = immCb;
                    legal = 1'b1;
                end
                5'b100_10: begin
                    // c.mv when bit 12 is clear, c.add when set
                    op.opClass = OP_ALU_REG;
                    op.rd = c[11:7];
                    op.rs1 = c[12] ? c[11:7] : 5'd0;
                    op.rs2 = c[6:2];
                    legal = (c[11:7] != 5'd0) && (c[6:2] != 5'd0);
                end
                default: begin
                    legal = 1'b0;
                end
            endcase
        end
        if (!legal) begin
            op = '0;
            op.isUnknown = 1'b1;
        end
    end
endmodule

// File: source/decodeStage.sv
// ********************
// one instruction per cycle, stall freezes out and blocks every pop
// ********************
`timescale 1ns/100ps
`include "rafiFront_defs.svh"

module decodeStage
    import rafiFrontPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  bufEntry_t readLow,
    input  bufEntry_t readHigh,
    input  logic [`BUF_CNT_W-1:0] readableCount,
    output logic popLow,
    output logic popHigh,
    output insnWord_u insn,
    output logic isCompressed,
    input  op_t op,
    output decodeOut_t out
);
    logic valid;
    trapInfo_t trap;
    decodeOut_t nextOut;

    always_comb begin
        isCompressed = readLow.insn[1:0] != 2'b11;
        // a 32-bit word needs both halves in the buffer
        valid = (isCompressed && readableCount != '0) || (readableCount >= `BUF_CNT_W'(2));
        insn.halves.low = readLow.insn;
        insn.halves.high = isCompressed ? 16'h0000 : readHigh.insn;
    end

    // trap priority, interrupts before faults before illegal encodings
    always_comb begin
        trap = '0;
        if (valid) begin
            if (readLow.interruptValid) begin
                trap.valid = 1'b1;
                trap.isInterrupt = 1'b1;
                trap.code = readLow.interruptCode;
                trap.value = readLow.pc;
            end
            else if (!isCompressed && readHigh.interruptValid) begin
                trap.valid = 1'b1;
                trap.isInterrupt = 1'b1;
                trap.code = readHigh.interruptCode;
                trap.value = readLow.pc;
            end
            else if (readLow.fault || (!isCompressed && readHigh.fault)) begin
                trap.valid = 1'b1;
                trap.code = `TRAP_INSN_PAGE_FAULT;
                trap.value = readLow.pc;
            end
            else if (op.isUnknown) begin
                trap.valid = 1'b1;
                trap.code = `TRAP_ILLEGAL_INSN;
                trap.value = insn;
            end
        end
    end

    assign popLow = valid && !stall;
    assign popHigh = valid && !isCompressed && !stall;

    always_comb begin
        nextOut = '0;
        if (valid) begin
            nextOut.valid = 1'b1;
            nextOut.pc = readLow.pc;
            nextOut.insn = insn;
            nextOut.op = op;
            nextOut.isCompressed = isCompressed;
            nextOut.csrAddr = insn[31:20];
            nextOut.trapInfo = trap;
        end
    end

    // empty cycles load an all-zero record
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out <= '0;
        end
        else if (!stall) begin
            out <= nextOut;
        end
    end
endmodule

// File: source/frontEnd.sv
// ********************
// stall and flush are plain levels, the writer must watch full
// ********************
`timescale 1ns/100ps
`include "rafiFront_defs.svh"

module frontEnd
    import rafiFrontPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  logic wrEn,
    input  bufEntry_t wrEntry,
    output logic full,
    output decodeOut_t out
);
    bufEntry_t readLow;
    bufEntry_t readHigh;
    logic [`BUF_CNT_W-1:0] readableCount;
    logic popLow;
    logic popHigh;
    insnWord_u insn;
    logic isCompressed;
    op_t op;

    insnBuffer buffer_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .wrEn(wrEn),
        .wrEntry(wrEntry),
        .full(full),
        .readLow(readLow),
        .readHigh(readHigh),
        .readableCount(readableCount),
        .popLow(popLow),
        .popHigh(popHigh)
    );

    decodeStage decode_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .readLow(readLow),
        .readHigh(readHigh),
        .readableCount(readableCount),
        .popLow(popLow),
        .popHigh(popHigh),
        .insn(insn),
        .isCompressed(isCompressed),
        .op(op),
        .out(out)
    );

    opDecoder decoder_i (
        .insn(insn),
        .isCompressed(isCompressed),
        .op(op)
    );
endmodule

// File: sim/frontEndMonitor.sv
// ********************
// a record counts when out is valid at an edge with stall and flush low
// ********************
`timescale 1ns/100ps

module frontEndMonitor
    import rafiFrontPkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input decodeOut_t out
);
    decodeOut_t expected[$];
    int errors = 0;
    int received = 0;
    int testErrors = 0;
    int testReceived = 0;

    task automatic addExpected(input decodeOut_t rec);
        expected.push_back(rec);
    endtask

    function automatic int pendingCount();
        return expected.size();
    endfunction

    task automatic checkField(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    always @(posedge clk) begin
        decodeOut_t e;
        if (!reset && !flush && !stall && out.valid) begin
            received++;
            testReceived++;
            if (expected.size() == 0) begin
                $display("unexpected record at %0t with pc %h", $time, out.pc);
                errors++;
                testErrors++;
            end
            else begin
                e = expected.pop_front();
                checkField("pc", e.pc, out.pc);
                checkField("insn", e.insn, out.insn);
                checkField("op.opClass", 32'(e.op.opClass), 32'(out.op.opClass));
                checkField("op.rd", 32'(e.op.rd), 32'(out.op.rd));
                checkField("op.rs1", 32'(e.op.rs1), 32'(out.op.rs1));
                checkField("op.rs2", 32'(e.op.rs2), 32'(out.op.rs2));
                checkField("op.imm", e.op.imm, out.op.imm);
                checkField("op.isUnknown", 32'(e.op.isUnknown), 32'(out.op.isUnknown));
                checkField("isCompressed", 32'(e.isCompressed), 32'(out.isCompressed));
                checkField("csrAddr", 32'(e.csrAddr), 32'(out.csrAddr));
                checkField("trap.valid", 32'(e.trapInfo.valid), 32'(out.trapInfo.valid));
                checkField("trap.isInterrupt", 32'(e.trapInfo.isInterrupt),
                           32'(out.trapInfo.isInterrupt));
                checkField("trap.code", 32'(e.trapInfo.code), 32'(out.trapInfo.code));
                checkField("trap.value", e.trapInfo.value, out.trapInfo.value);
            end
        end
    end

    task automatic reportTest(input int testId);
        $display("test %0d done: %0d records, %0d errors", testId, testReceived, testErrors);
        testReceived = 0;
        testErrors = 0;
    endtask
endmodule

// File: sim/decodeStage_chk.sv
// ********************
// bound into the front end top, sees buffer and stage wires together
// ********************
`timescale 1ns/100ps

module decodeStage_chk
    import rafiFrontPkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic wrEn,
    input logic full,
    input logic popLow,
    input logic popHigh,
    input decodeOut_t out
);
    noWriteWhenFull: assert property (@(posedge clk) disable iff (reset) wrEn |-> !full)
        else $error("write while buffer full");

    popHighNeedsLow: assert property (@(posedge clk) disable iff (reset) popHigh |-> popLow)
        else $error("popHigh without popLow");

    // frozen output under stall
    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        stall && !flush |=> $stable(out))
        else $error("out changed during stall");

    clearAfterFlush: assert property (@(posedge clk) disable iff (reset) flush |=> !out.valid)
        else $error("out valid after flush");
endmodule

bind frontEnd decodeStage_chk chk_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .flush(flush),
    .wrEn(wrEn),
    .full(full),
    .popLow(popLow),
    .popHigh(popHigh),
    .out(out)
);

// File: sim/frontEndTb.sv
// ********************
// halfwords go in every other cycle so full is always seen in time
// ********************
`timescale 1ns/100ps
`include "rafiFront_defs.svh"

module frontEndTb
    import rafiFrontPkg::*;
();
    typedef struct {
        int testId;
        logic [31:0] pc;
        logic [31:0] word;
        logic faultLow;
        logic faultHigh;
        logic irqLow;
        logic irqHigh;
        logic [3:0] codeLow;
        logic [3:0] codeHigh;
        int gap;
        op_t op;
    } stimRow_t;

    logic clk;
    logic reset;
    logic stall;
    logic flush;
    logic wrEn;
    bufEntry_t wrEntry;
    logic full;
    decodeOut_t out;

    stimRow_t rows[$];
    logic [31:0] nextPc;
    logic [31:0] lcgState;
    logic randomStall;
    int failures;
    int testCount;

    frontEnd dut_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .wrEn(wrEn),
        .wrEntry(wrEntry),
        .full(full),
        .out(out)
    );

    frontEndMonitor monitor_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .out(out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // random stall level while test 5 runs
    always @(posedge clk) begin
        if (randomStall) begin
            lcgState = lcgNext(lcgState);
            stall <= lcgState[16];
        end
    end

    function automatic op_t mkOp(input opClass_e cls, input logic [4:0] rd,
                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                 input logic [31:0] imm);
        op_t o;
        o = '0;
        o.opClass = cls;
        o.rd = rd;
        o.rs1 = rs1;
        o.rs2 = rs2;
        o.imm = imm;
        return o;
    endfunction

    function automatic op_t unknownOp();
        op_t o;
        o = '0;
        o.isUnknown = 1'b1;
        return o;
    endfunction

    // pc advances by two or four as bits 1:0 say
    task automatic addRow(input int testId, input logic [31:0] word, input op_t op);
        stimRow_t r;
        r = '{default: '0};
        r.testId = testId;
        r.pc = nextPc;
        r.word = word;
        r.op = op;
        rows.push_back(r);
        nextPc = nextPc + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
    endtask

    task automatic markLast(input logic faultLow, input logic faultHigh, input logic irqLow,
                            input logic [3:0] codeLow, input logic irqHigh,
                            input logic [3:0] codeHigh);
        int n;
        n = rows.size() - 1;
        rows[n].faultLow = faultLow;
        rows[n].faultHigh = faultHigh;
        rows[n].irqLow = irqLow;
        rows[n].codeLow = codeLow;
        rows[n].irqHigh = irqHigh;
        rows[n].codeHigh = codeHigh;
    endtask

    // interrupt low, interrupt high, page fault, then illegal encoding
    function automatic decodeOut_t expectedFor(input stimRow_t r);
        decodeOut_t e;
        logic comp;
        logic [31:0] word;
        comp = r.word[1:0] != 2'b11;
        word = comp ? {16'h0000, r.word[15:0]} : r.word;
        e = '0;
        e.valid = 1'b1;
        e.pc = r.pc;
        e.insn = word;
        e.op = r.op;
        e.isCompressed = comp;
        e.csrAddr = word[31:20];
        if (r.irqLow) begin
            e.trapInfo = '{1'b1, 1'b1, r.codeLow, r.pc};
        end
        else if (!comp && r.irqHigh) begin
            e.trapInfo = '{1'b1, 1'b1, r.codeHigh, r.pc};
        end
        else if (r.faultLow || (!comp && r.faultHigh)) begin
            e.trapInfo = '{1'b1, 1'b0, 4'd12, r.pc};
        end
        else if (r.op.isUnknown) begin
            e.trapInfo = '{1'b1, 1'b0, 4'd2, word};
        end
        return e;
    endfunction

    task automatic pushHalf(input bufEntry_t e);
        int waited;
        waited = 0;
        @(negedge clk);
        while (full && waited < 200) begin
            waited++;
            @(negedge clk);
        end
        if (full) begin
            $display("timeout: buffer stayed full at %0t", $time);
            failures++;
        end
        else begin
            @(posedge clk);
            wrEn <= 1'b1;
            wrEntry <= e;
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    task automatic applyRow(input stimRow_t r);
        pushHalf('{r.pc, r.word[15:0], r.faultLow, r.irqLow, r.codeLow});
        if (r.word[1:0] == 2'b11) begin
            repeat (r.gap) @(posedge clk);
            pushHalf('{r.pc + 32'd2, r.word[31:16], r.faultHigh, r.irqHigh, r.codeHigh});
        end
        monitor_i.addExpected(expectedFor(r));
    endtask

    // out holds a record and the stalled buffer fills before the flush drops both
    task automatic flushSequence();
        pushHalf('{32'h0000_9000, 16'h028D, 1'b0, 1'b0, 4'd0});
        @(posedge clk);
        stall <= 1'b1;
        for (int k = 0; k < `BUF_DEPTH; k++) begin
            pushHalf('{32'h0000_9002 + 32'(2 * k), 16'h5579, 1'b0, 1'b0, 4'd0});
        end
        @(negedge clk);
        if (full !== 1'b1) begin
            $display("mismatch at %0t: full expected 1 actual %b", $time, full);
            failures++;
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
    endtask

    task automatic endTest(input int testId);
        int waited;
        waited = 0;
        while (monitor_i.pendingCount() != 0 && waited < 500) begin
            waited++;
            @(posedge clk);
        end
        if (monitor_i.pendingCount() != 0) begin
            $display("timeout: test %0d still waits for %0d records", testId,
                     monitor_i.pendingCount());
            failures++;
        end
        randomStall = 1'b0;
        @(posedge clk);
        stall <= 1'b0;
        // a few idle cycles so stray records show up in this test
        repeat (4) @(posedge clk);
        monitor_i.reportTest(testId);
        testCount++;
    endtask

    task automatic buildTable();
        addRow(1, 32'h002081B3, mkOp(OP_ALU_REG, 5'd3, 5'd1, 5'd2, 32'h0));
        addRow(1, 32'hFFF30293, mkOp(OP_ALU_IMM, 5'd5, 5'd6, 5'd0, 32'hFFFFFFFF));
        addRow(1, 32'h00812383, mkOp(OP_LOAD, 5'd7, 5'd2, 5'd0, 32'd8));
        addRow(1, 32'h00952623, mkOp(OP_STORE, 5'd0, 5'd10, 5'd9, 32'd12));
        addRow(1, 32'h00208863, mkOp(OP_BRANCH, 5'd0, 5'd1, 5'd2, 32'd16));
        addRow(1, 32'h001000EF, mkOp(OP_JAL, 5'd1, 5'd0, 5'd0, 32'h800));
        addRow(1, 32'h00408067, mkOp(OP_JALR, 5'd0, 5'd1, 5'd0, 32'd4));
        addRow(1, 32'h12345237, mkOp(OP_LUI, 5'd4, 5'd0, 5'd0, 32'h12345000));
        addRow(1, 32'h00001317, mkOp(OP_AUIPC, 5'd6, 5'd0, 5'd0, 32'h1000));
        addRow(1, 32'h300110F3, mkOp(OP_SYSTEM, 5'd1, 5'd2, 5'd0, 32'h300));
        // compressed forms mixed with a full word
        addRow(2, 32'h028D, mkOp(OP_ALU_IMM, 5'd5, 5'd5, 5'd0, 32'd3));
        addRow(2, 32'h5579, mkOp(OP_ALU_IMM, 5'd10, 5'd0, 5'd0, 32'hFFFFFFFE));
        addRow(2, 32'h4044, mkOp(OP_LOAD, 5'd9, 5'd8, 5'd0, 32'd4));
        addRow(2, 32'hC60C, mkOp(OP_STORE, 5'd0, 5'd12, 5'd11, 32'd8));
        addRow(2, 32'hBFF5, mkOp(OP_JAL, 5'd0, 5'd0, 5'd0, 32'hFFFFFFFC));
        addRow(2, 32'hC019, mkOp(OP_BRANCH, 5'd0, 5'd8, 5'd0, 32'd6));
        addRow(2, 32'h829A, mkOp(OP_ALU_REG, 5'd5, 5'd0, 5'd6, 32'h0));
        addRow(2, 32'h002081B3, mkOp(OP_ALU_REG, 5'd3, 5'd1, 5'd2, 32'h0));
        addRow(2, 32'h93A2, mkOp(OP_ALU_REG, 5'd7, 5'd7, 5'd8, 32'h0));
        // traps
        addRow(3, 32'h002081B3, mkOp(OP_ALU_REG, 5'd3, 5'd1, 5'd2, 32'h0));
        markLast(1'b0, 1'b1, 1'b1, 4'd7, 1'b0, 4'd0);
        addRow(3, 32'h00812383, mkOp(OP_LOAD, 5'd7, 5'd2, 5'd0, 32'd8));
        markLast(1'b1, 1'b0, 1'b0, 4'd0, 1'b1, 4'd3);
        addRow(3, 32'h00001317, mkOp(OP_AUIPC, 5'd6, 5'd0, 5'd0, 32'h1000));
        markLast(1'b0, 1'b1, 1'b0, 4'd0, 1'b0, 4'd0);
        addRow(3, 32'h12345677, unknownOp());
        addRow(3, 32'h0000, unknownOp());
        addRow(3, 32'h028D, mkOp(OP_ALU_IMM, 5'd5, 5'd5, 5'd0, 32'd3));
        markLast(1'b0, 1'b0, 1'b1, 4'd5, 1'b0, 4'd0);
        addRow(4, 32'h00952623, mkOp(OP_STORE, 5'd0, 5'd10, 5'd9, 32'd12));
        rows[rows.size() - 1].gap = 12;
        for (int i = 0; i < 3; i++) begin
            addRow(5, 32'h00208863, mkOp(OP_BRANCH, 5'd0, 5'd1, 5'd2, 32'd16));
            addRow(5, 32'hC60C, mkOp(OP_STORE, 5'd0, 5'd12, 5'd11, 32'd8));
            addRow(5, 32'h12345237, mkOp(OP_LUI, 5'd4, 5'd0, 5'd0, 32'h12345000));
            addRow(5, 32'h93A2, mkOp(OP_ALU_REG, 5'd7, 5'd7, 5'd8, 32'h0));
        end
        addRow(6, 32'h5579, mkOp(OP_ALU_IMM, 5'd10, 5'd0, 5'd0, 32'hFFFFFFFE));
        addRow(6, 32'h00408067, mkOp(OP_JALR, 5'd0, 5'd1, 5'd0, 32'd4));
    endtask

    initial begin
        int total;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        wrEn = 1'b0;
        wrEntry = '0;
        randomStall = 1'b0;
        lcgState = 32'd10;
        nextPc = 32'h0000_1000;
        failures = 0;
        testCount = 0;
        buildTable();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            if (i == 0 || rows[i].testId != rows[i - 1].testId) begin
                if (i > 0) begin
                    endTest(rows[i - 1].testId);
                end
                if (rows[i].testId == 5) begin
                    randomStall = 1'b1;
                end
                if (rows[i].testId == 6) begin
                    flushSequence();
                end
            end
            applyRow(rows[i]);
        end
        endTest(rows[rows.size() - 1].testId);
        total = monitor_i.errors + failures;
        $display("%0d tests, %0d records, %0d mismatches, %0d other failures", testCount,
                 monitor_i.received, monitor_i.errors, failures);
        if (total == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    end
endmodule

// File: sim.f
+incdir+source
source/rafiFrontPkg.sv
source/insnBuffer.sv
source/opDecoder.sv
source/decodeStage.sv
source/frontEnd.sv
sim/frontEndMonitor.sv
sim/decodeStage_chk.sv
sim/frontEndTb.sv

// File: Bender.yml
package:
  name: rafi_front

sources:
  - include_dirs:
      - source
    files:
      - source/rafiFrontPkg.sv
      - source/insnBuffer.sv
      - source/opDecoder.sv
      - source/decodeStage.sv
      - source/frontEnd.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/frontEndMonitor.sv
      - sim/decodeStage_chk.sv
      - sim/frontEndTb.sv
